// File: sim.f
hdl/fir_pkg.sv
hdl/coeff_bank.sv
hdl/coeff_arbiter.sv
hdl/coeff_loader.sv
hdl/fir_mac_engine.sv
hdl/fir_subsystem_top.sv
verification/fir_sva.sv
verification/fir_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := fir_tb
FILELIST := sim.f
BUILD    := obj_dir
LOG      := sim.log
RUNFLAGS := +verilator+error+limit+100
PASS     := *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: build
	./$(BUILD)/V$(TOP) $(RUNFLAGS) 2>&1 | tee $(LOG)
	@grep -qF "$(PASS)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

lint:
	$(SIM) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

// File: verification/fir_tb.sv
// Random stimulus from seed 75 against a FIR model kept inside the testbench
// Model coefficients change when a write's ack is seen; results must come in sample order
`timescale 1ns/1ps

module fir_tb import fir_pkg::*; ();

    localparam int max_cycles = 400 * 40;   // Transfers times worst-case cycles each

    logic      clk;
    logic      rst;
    logic      sample_req;
    sample_t   sample_data;
    logic      sample_ack;
    logic      result_req;
    sample_t   result;
    logic      result_ack;
    logic      coeff_req;
    tap_addr_t coeff_addr;
    sample_t   coeff_data;
    logic      coeff_ack;
    logic      coeff_ack_q;   // Previous coeff_ack, for edge detect

    sample_t model_coeff [num_taps];
    sample_t model_delay [num_taps];   // [0] holds the newest sample
    int      errors;
    int      writes_sent;
    int      writes_acked;
    int      cycle_count;

    fir_subsystem_top dut_i (
        .clk, .rst,
        .sample_req_i(sample_req), .sample_i(sample_data), .sample_ack_o(sample_ack),
        .result_req_o(result_req), .result_o(result), .result_ack_i(result_ack),
        .coeff_req_i(coeff_req), .coeff_addr_i(coeff_addr), .coeff_data_i(coeff_data),
        .coeff_ack_o(coeff_ack)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", max_cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // Count acks as the DUT raises them, apart from the write task
    always @(posedge clk) begin
        coeff_ack_q <= coeff_ack;
        if (coeff_ack && !coeff_ack_q) begin
            writes_acked++;
        end
    end

    // Just past the edge, where inputs change and outputs have settled
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input sample_t got, input sample_t expected, input string what);
        if (got !== expected) begin
            $display("** Error at %0d ns: %s expected %h received %h", $time, what, expected, got);
            errors++;
        end
    endtask

    // Shift in one sample, return the truncated sum of products
    function automatic sample_t model_filter(input sample_t data);
        sample_t acc;
        acc = '0;
        for (int k = num_taps - 1; k > 0; k--) begin
            model_delay[k] = model_delay[k-1];
        end
        model_delay[0] = data;
        for (int k = 0; k < num_taps; k++) begin
            acc = acc + model_delay[k] * model_coeff[k];
        end
        return acc;
    endfunction

    task automatic apply_reset();
        rst         = 1'b1;
        sample_req  = 1'b0;
        sample_data = '0;
        result_ack  = 1'b0;
        coeff_req   = 1'b0;
        coeff_addr  = '0;
        coeff_data  = '0;
        repeat (2) step();
        rst = 1'b0;
        for (int k = 0; k < num_taps; k++) begin
            model_coeff[k] = sample_t'(k);   // Index values, as the bank
            model_delay[k] = '0;
        end
        check_value(sample_t'({sample_ack, result_req, coeff_ack}), '0, "acks after reset");
    endtask

    task automatic write_coeff(input tap_addr_t addr, input sample_t data);
        coeff_req  = 1'b1;
        coeff_addr = addr;
        coeff_data = data;
        writes_sent++;
        step();
        while (!coeff_ack) step();
        model_coeff[addr] = data;   // Used by every sample acked after this
        coeff_req = 1'b0;
        step();
        while (coeff_ack) step();
    endtask

    // Full sample and result exchange, result ack held off up to max_delay cycles
    task automatic send_sample(input sample_t data, input int max_delay);
        sample_t expected;
        check_value(sample_t'(result_req), '0, "result_req before sample");
        sample_req  = 1'b1;
        sample_data = data;
        step();
        while (!sample_ack) step();
        expected   = model_filter(data);
        sample_req = 1'b0;
        step();
        while (sample_ack) step();
        while (!result_req) step();
        check_value(result, expected, "filter result");
        repeat ($urandom_range(max_delay, 0)) step();
        result_ack = 1'b1;
        step();
        while (result_req) step();
        result_ack = 1'b0;
    endtask

    initial begin
        tap_addr_t addr;
        int        assert_errors;
        void'($urandom(75));
        errors       = 0;
        writes_sent  = 0;
        writes_acked = 0;
        cycle_count  = 0;
        apply_reset();

        // Index coefficients only
        repeat (20) begin
            repeat ($urandom_range(3, 0)) step();
            send_sample($urandom(), 0);
        end

        // Coefficient writes between samples
        repeat (30) begin
            repeat ($urandom_range(2, 0)) begin
                write_coeff(tap_addr_t'($urandom_range(num_taps - 1, 0)), $urandom());
            end
            send_sample($urandom(), 0);
        end

        repeat (20) send_sample($urandom(), 20);   // Slow result host

        // Same-value rewrites racing the tap reads for the bank
        fork
            repeat (30) send_sample($urandom(), 0);
            repeat (30) begin
                addr = tap_addr_t'($urandom_range(num_taps - 1, 0));
                repeat ($urandom_range(4, 0)) step();
                write_coeff(addr, model_coeff[addr]);
            end
        join
        check_value(sample_t'(writes_acked), sample_t'(writes_sent), "coefficient acks");

        // Reset while the engine is partway through its taps
        write_coeff(tap_addr_t'(1), $urandom());
        sample_req  = 1'b1;
        sample_data = $urandom();
        step();
        while (!sample_ack) step();
        sample_req = 1'b0;
        repeat (6) step();
        apply_reset();
        repeat (3) send_sample($urandom(), 0);

        assert_errors = dut_i.arbiter_i.arb_sva_i.fail_count
                      + dut_i.engine_i.eng_sva_i.fail_count;
        $display("Run complete: %0d value errors, %0d assertion failures", errors, assert_errors);
        if (errors == 0 && assert_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: verification/fir_sva.sv
// Grant and handshake checks, bound into the arbiter and the MAC engine
// Inputs a target lacks are tied low in its bind, so those checks hold trivially there
`timescale 1ns/1ps

module fir_sva_checks (
    input logic clk,
    input logic rst,
    input logic req_a_i,
    input logic req_b_i,
    input logic gnt_a_i,
    input logic gnt_b_i,
    input logic hs_req_i,
    input logic hs_ack_i
);

    int fail_count = 0;   // Summed by the testbench at the end

    // At most one bank grant per cycle
    one_grant: assert property (@(posedge clk) disable iff (rst) !(gnt_a_i && gnt_b_i))
        else begin
            fail_count++;
            $error("Both bank grants are high in the same cycle");
        end

    grant_a_has_req: assert property (@(posedge clk) disable iff (rst) gnt_a_i |-> req_a_i)
        else begin
            fail_count++;
            $error("Grant A given without a request");
        end

    grant_b_has_req: assert property (@(posedge clk) disable iff (rst) gnt_b_i |-> req_b_i)
        else begin
            fail_count++;
            $error("Grant B given without a request");
        end

    // Four-phase ack stays up while the request is up
    ack_held: assert property (@(posedge clk) disable iff (rst)
                               (hs_ack_i && hs_req_i) |=> hs_ack_i)
        else begin
            fail_count++;
            $error("Sample ack dropped before the request fell");
        end

endmodule

bind coeff_arbiter fir_sva_checks arb_sva_i (
    .clk(clk), .rst(rst),
    .req_a_i(loader_req_i), .req_b_i(engine_req_i),
    .gnt_a_i(loader_gnt_o), .gnt_b_i(engine_gnt_o),
    .hs_req_i(1'b0), .hs_ack_i(1'b0)
);

bind fir_mac_engine fir_sva_checks eng_sva_i (
    .clk(clk), .rst(rst),
    .req_a_i(bank_req_o), .req_b_i(1'b0),
    .gnt_a_i(bank_gnt_i), .gnt_b_i(1'b0),
    .hs_req_i(sample_req_i), .hs_ack_i(sample_ack_o)
);

// File: hdl/fir_subsystem_top.sv
// FIR subsystem: sample, result and coefficient host ports, all four-phase
// Coefficient writes share the bank with tap reads, so result latency varies
`timescale 1ns/1ps

module fir_subsystem_top import fir_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    // Sample in
    input  logic      sample_req_i,
    input  sample_t   sample_i,
    output logic      sample_ack_o,
    // Result out
    output logic      result_req_o,
    output sample_t   result_o,
    input  logic      result_ack_i,
    // Coefficient writes
    input  logic      coeff_req_i,
    input  tap_addr_t coeff_addr_i,
    input  sample_t   coeff_data_i,
    output logic      coeff_ack_o
);

    logic      loader_req, loader_gnt;
    logic      engine_req, engine_gnt;
    bank_req_t loader_cmd, engine_cmd, bank_cmd;
    logic      bank_valid;
    sample_t   bank_rdata;

    coeff_loader loader_i (
        .clk, .rst, .coeff_req_i, .coeff_addr_i, .coeff_data_i, .coeff_ack_o,
        .bank_req_o(loader_req), .bank_cmd_o(loader_cmd), .bank_gnt_i(loader_gnt)
    );

    fir_mac_engine engine_i (
        .clk, .rst, .sample_req_i, .sample_i, .sample_ack_o,
        .result_req_o, .result_o, .result_ack_i,
        .bank_req_o(engine_req), .bank_cmd_o(engine_cmd),
        .bank_gnt_i(engine_gnt), .bank_rdata_i(bank_rdata)
    );

    coeff_arbiter arbiter_i (
        .clk, .rst,
        .loader_req_i(loader_req), .loader_cmd_i(loader_cmd),
        .engine_req_i(engine_req), .engine_cmd_i(engine_cmd),
        .loader_gnt_o(loader_gnt), .engine_gnt_o(engine_gnt),
        .bank_cmd_o(bank_cmd), .bank_valid_o(bank_valid)
    );

    coeff_bank bank_i (
        .clk, .rst, .req_i(bank_cmd), .valid_i(bank_valid), .rdata_o(bank_rdata)
    );

endmodule

// File: hdl/fir_mac_engine.sv
// Sequential 8-tap FIR, one bank read and one multiply-accumulate per tap
// Products and sum truncated to 32 bits; no new sample until result_ack_i is low
`timescale 1ns/1ps

module fir_mac_engine import fir_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      sample_req_i,
    input  sample_t   sample_i,
    output logic      sample_ack_o,
    output logic      result_req_o,
    output sample_t   result_o,
    input  logic      result_ack_i,
    output logic      bank_req_o,
    output bank_req_t bank_cmd_o,
    input  logic      bank_gnt_i,
    input  sample_t   bank_rdata_i
);

    engine_state_t state_q;
    tap_addr_t     tap_q;
    sample_t       acc_q;
    sample_t       delay_q [num_taps];   // delay_q[0] is the newest sample
    logic          last_tap;

    assign last_tap = (tap_q == tap_addr_t'(num_taps - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q      <= IDLE;
            tap_q        <= '0;
            acc_q        <= '0;
            sample_ack_o <= 1'b0;
            result_req_o <= 1'b0;
            for (int k = 0; k < num_taps; k++) begin
                delay_q[k] <= '0;
            end
        end else begin
            // Ack follows the host request down, whatever the state
            if (sample_ack_o && !sample_req_i) begin
                sample_ack_o <= 1'b0;
            end

            case (state_q)
                IDLE: begin
                    // Previous result handshake must be fully closed
                    if (sample_req_i && !sample_ack_o && !result_ack_i) begin
                        delay_q[0] <= sample_i;
                        for (int k = 1; k < num_taps; k++) begin
                            delay_q[k] <= delay_q[k-1];
                        end
                        sample_ack_o <= 1'b1;
                        tap_q        <= '0;
                        acc_q        <= '0;
                        state_q      <= FETCH;
                    end
                end
                FETCH: begin
                    if (bank_gnt_i) state_q <= MAC;   // Coefficient valid next cycle
                end
                MAC: begin
                    acc_q <= acc_q + delay_q[tap_q] * bank_rdata_i;
                    if (last_tap) begin
                        result_req_o <= 1'b1;
                        state_q      <= DONE;
                    end else begin
                        tap_q   <= tap_q + 1'b1;
                        state_q <= FETCH;
                    end
                end
                DONE: begin
                    if (result_ack_i) begin
                        result_req_o <= 1'b0;
                        state_q      <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Accumulator holds the finished sum through DONE
    assign result_o = acc_q;

    assign bank_req_o = (state_q == FETCH);
    assign bank_cmd_o = '{we: 1'b0, addr: tap_q, wdata: '0};

endmodule

// File: hdl/coeff_loader.sv
// Host coefficient write port, four-phase req/ack
// Each host transfer becomes exactly one bank write; addr and data sampled at request
`timescale 1ns/1ps

module coeff_loader import fir_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      coeff_req_i,
    input  tap_addr_t coeff_addr_i,
    input  sample_t   coeff_data_i,
    output logic      coeff_ack_o,
    output logic      bank_req_o,
    output bank_req_t bank_cmd_o,
    input  logic      bank_gnt_i
);

    typedef enum logic [1:0] {
        L_WAIT,   // Idle, ack low
        L_REQ,    // Holding the bank request
        L_ACK     // Write done, ack high
    } loader_state_t;

    loader_state_t state_q;
    tap_addr_t     addr_q;
    sample_t       data_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= L_WAIT;
        end else begin
            case (state_q)
                L_WAIT:  if (coeff_req_i) state_q <= L_REQ;
                L_REQ:   if (bank_gnt_i) state_q <= L_ACK;   // Write lands this cycle
                L_ACK:   if (!coeff_req_i) state_q <= L_WAIT;
                default: state_q <= L_WAIT;
            endcase
        end
    end

    // Capture the host payload on accept
    always_ff @(posedge clk) begin
        if (state_q == L_WAIT && coeff_req_i) begin
            addr_q <= coeff_addr_i;
            data_q <= coeff_data_i;
        end
    end

    assign bank_req_o  = (state_q == L_REQ);
    assign coeff_ack_o = (state_q == L_ACK);
    assign bank_cmd_o  = '{we: 1'b1, addr: addr_q, wdata: data_q};

endmodule

// File: hdl/coeff_arbiter.sv
// Round-robin between loader and engine for the single bank port
// Grants are combinational; a peer must drop its request the cycle after its grant
`timescale 1ns/1ps

module coeff_arbiter import fir_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      loader_req_i,
    input  bank_req_t loader_cmd_i,
    input  logic      engine_req_i,
    input  bank_req_t engine_cmd_i,
    output logic      loader_gnt_o,
    output logic      engine_gnt_o,
    output bank_req_t bank_cmd_o,
    output logic      bank_valid_o
);

    logic last_engine_q;   // 1 when the engine had the last grant

    // On conflict the peer not served last wins
    always_comb begin
        loader_gnt_o = 1'b0;
        engine_gnt_o = 1'b0;
        if (loader_req_i && engine_req_i) begin
            if (last_engine_q) begin
                loader_gnt_o = 1'b1;
            end else begin
                engine_gnt_o = 1'b1;
            end
        end else begin
            loader_gnt_o = loader_req_i;
            engine_gnt_o = engine_req_i;
        end
    end

    // Winner's command goes straight to the bank
    assign bank_cmd_o   = engine_gnt_o ? engine_cmd_i : loader_cmd_i;
    assign bank_valid_o = loader_gnt_o | engine_gnt_o;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_engine_q <= 1'b0;   // Engine wins the first conflict
        end else if (engine_gnt_o) begin
            last_engine_q <= 1'b1;
        end else if (loader_gnt_o) begin
            last_engine_q <= 1'b0;
        end
    end

endmodule

// File: hdl/coeff_bank.sv
// Single-port coefficient store, one access per valid cycle
// Reads return one cycle later on rdata_o; reset loads entry k with k
`timescale 1ns/1ps

module coeff_bank import fir_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  bank_req_t req_i,
    input  logic      valid_i,
    output sample_t   rdata_o
);

    sample_t coeff_q [num_taps];

    // Storage with index-valued reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int k = 0; k < num_taps; k++) begin
                coeff_q[k] <= sample_t'(k);
            end
        end else if (valid_i && req_i.we) begin
            coeff_q[req_i.addr] <= req_i.wdata;
        end
    end

    // Registered read port
    always_ff @(posedge clk) begin
        if (valid_i && !req_i.we) begin
            rdata_o <= coeff_q[req_i.addr];
        end
    end

endmodule

// File: hdl/fir_pkg.sv
// Shared widths, types and state encoding for the FIR subsystem
// Tap count is fixed here; samples, coefficients and results share one width
package fir_pkg;

    localparam int num_taps     = 8;   // Filter length
    localparam int coeff_addr_w = 3;   // Enough to index num_taps entries
    localparam int sample_w     = 32;

    // Samples, coefficients and results all use this width
    typedef logic [sample_w-1:0] sample_t;

    // Tap index, also the coefficient bank address
    typedef logic [coeff_addr_w-1:0] tap_addr_t;

    // Command to the coefficient bank, 36 bits
    typedef struct packed {
        logic      we;      // 1 write, 0 read
        tap_addr_t addr;
        sample_t   wdata;   // Ignored on reads
    } bank_req_t;

    // MAC engine sequencing
    typedef enum logic [1:0] {
        IDLE,   // Waiting for a sample
        FETCH,  // Bank read request for the current tap
        MAC,    // Coefficient back, accumulate
        DONE    // Result handshake with the host
    } engine_state_t;

endpackage
